// ==== cs_params.svh ====
`ifndef CS_PARAMS_SVH
`define CS_PARAMS_SVH

// tile geometry, one 16x16 bayer tile
`define CS_TILE_PIXELS 256

// extra latency of the jp4diff window over plain jp4
`define CS_JP4DIFF_DELAY 17

// apb slave address width and register map
`define CS_APB_AW 4
`define CS_REG_MODE 4'h0
`define CS_REG_STATUS 4'h4

`endif

// ==== cs_pkg.sv ====
package cs_pkg;

    // converter mode codes, numbering kept from the camera register map
    typedef enum logic [2:0] {
        CS_MONO16  = 3'd2, // monochrome, 16x16 tile
        CS_JP4     = 3'd3, // bayer split into four 8x8 blocks
        CS_JP4DIFF = 3'd4  // jp4 with per-cell base differences
    } cs_conv_e;

    // per-frame configuration, frame_en ends up in bit 0
    typedef struct packed {
        logic [1:0] bayer_phase; // base pixel position in the 2x2 cell
        logic       hdr;         // second green absolute
        logic       scale_diff;  // halve differences
        cs_conv_e   conv_type;
        logic       frame_en;
    } cs_cfg_t;

    // one sample to the external tile buffer
    typedef struct packed {
        logic              we;
        logic [7:0]        addr;
        logic signed [8:0] y;
    } cs_pix_t;

    // unsigned pixel to signed sample, black at -128
    function automatic logic signed [8:0] cs_level_shift(input logic [7:0] d);
        return $signed({1'b0, d}) - 9'sd128;
    endfunction

endpackage

// ==== cs_apb_regs.sv ====
`include "cs_params.svh"

module cs_apb_regs (
    input  logic                   xclk,
    input  logic                   rst,
    input  logic [`CS_APB_AW-1:0]  paddr,
    input  logic                   psel,
    input  logic                   penable,
    input  logic                   pwrite,
    input  logic [31:0]            pwdata,
    output logic [31:0]            prdata,
    output logic                   pready,
    output logic                   pslverr,
    output cs_pkg::cs_cfg_t        cfg,
    input  logic                   tile_done  // one pulse per enabled tile
);
    import cs_pkg::*;

    logic        access;     // apb access phase
    logic        sel_mode;
    logic        sel_status;
    logic        type_ok;    // written conv_type is a known mode
    logic        bad_access;
    logic [15:0] tile_cnt;

    assign access     = psel & penable;
    assign sel_mode   = paddr == `CS_REG_MODE;
    assign sel_status = paddr == `CS_REG_STATUS;

    // only the three kept modes are legal
    always_comb begin
        case (pwdata[3:1])
            CS_MONO16, CS_JP4, CS_JP4DIFF: type_ok = 1'b1;
            default:                       type_ok = 1'b0;
        endcase
    end

    // unmapped address, or mode write with an unknown converter
    assign bad_access = !(sel_mode || sel_status) || (sel_mode && pwrite && !type_ok);

    assign pready  = 1'b1;                  // zero wait states
    assign pslverr = access & bad_access;

    always_comb begin
        prdata = 32'h0;
        if (sel_mode)
            prdata = {24'h0, cfg};          // same layout as cs_cfg_t
        else if (sel_status)
            prdata = {16'h0, tile_cnt};
    end

    always_ff @(posedge xclk) begin
        if (rst) begin
            cfg <= '0;                      // frame disabled
        end else if (access && pwrite && sel_mode && type_ok) begin
            cfg <= cs_cfg_t'(pwdata[7:0]);
        end
    end

    // status is read-only and ignores writes
    always_ff @(posedge xclk) begin
        if (rst)
            tile_cnt <= 16'h0;
        else if (tile_done)
            tile_cnt <= tile_cnt + 16'h1;   // wraps
    end

    a_no_wait: assert property (@(posedge xclk) disable iff (rst) psel |-> pready);

endmodule

// ==== cs_mono16.sv ====
`include "cs_params.svh"

module cs_mono16 (
    input  logic            xclk,
    input  logic            en,
    input  logic [7:0]      din,
    input  logic            pre_first_in,
    output cs_pkg::cs_pix_t pix,
    output logic            pre_first_out
);
    import cs_pkg::*;

    localparam int unsigned LAST = `CS_TILE_PIXELS - 1;

    logic [7:0] cnt;  // raster index of the pixel on din
    logic       act;  // inside a tile

    always_ff @(posedge xclk) begin
        if (pre_first_in)
            cnt <= 8'h0;
        else
            cnt <= cnt + 8'h1;

        if (pre_first_in)
            act <= 1'b1;
        else if (cnt == LAST[7:0] || !en)
            act <= 1'b0;  // stop after pixel 255
    end

    always_ff @(posedge xclk) begin
        pix.we        <= en & act;
        pix.addr      <= cnt;              // row in high nibble, column in low
        pix.y         <= cs_level_shift(din);
        pre_first_out <= pre_first_in;
    end

endmodule

// ==== cs_jp4.sv ====
`include "cs_params.svh"

module cs_jp4 (
    input  logic            xclk,
    input  logic            en,
    input  logic [7:0]      din,
    input  logic            pre_first_in,
    output cs_pkg::cs_pix_t pix,
    output logic            pre_first_out
);
    import cs_pkg::*;

    localparam int unsigned LAST = `CS_TILE_PIXELS - 1;

    logic [7:0] cnt;   // {row, col} of the pixel on din
    logic       act;
    logic [7:0] addr;  // color-split address, before block remap

    always_ff @(posedge xclk) begin
        if (pre_first_in)
            cnt <= 8'h0;
        else
            cnt <= cnt + 8'h1;

        if (pre_first_in)
            act <= 1'b1;
        else if (cnt == LAST[7:0] || !en)
            act <= 1'b0;
    end

    // row/col parity go to the top of each half, so each bayer color
    // gets its own quadrant once cs_convert swaps bits
    assign addr = {cnt[4], cnt[7:5], cnt[0], cnt[3:1]};

    always_ff @(posedge xclk) begin
        pix.we        <= en & act;
        pix.addr      <= addr;
        pix.y         <= cs_level_shift(din);
        pre_first_out <= pre_first_in;
    end

endmodule

// ==== cs_jp4diff.sv ====
`include "cs_params.svh"

module cs_jp4diff (
    input  logic            xclk,
    input  logic            en,
    input  logic [7:0]      din,
    input  logic            pre_first_in,
    input  logic            scale_diff,
    input  logic            hdr,
    input  logic [1:0]      bayer_phase,
    output cs_pkg::cs_pix_t pix,
    output logic            pre_first_out
);
    import cs_pkg::*;

    localparam int DLY = `CS_JP4DIFF_DELAY;
    localparam int unsigned LAST = `CS_TILE_PIXELS - 1;

    logic [7:0]        sr [0:DLY-1];    // sr[0] is pixel i, din is pixel i+17
    logic [DLY-1:0]    pfi_dl;          // tile start, delayed to the window
    logic [DLY-1:0]    en_dl;           // enable travels with the pixels
    logic [7:0]        cnt;             // raster index of sr[0]
    logic              act;
    logic              scale_l;
    logic              hdr_l;
    logic [1:0]        bp_l;
    logic [7:0]        base_mem [0:7];  // one base per cell of the row pair
    logic [7:0]        cell_base;
    logic [7:0]        base;
    logic [1:0]        pix_par;         // {row, col} parity of sr[0]
    logic              top_left;
    logic signed [8:0] diff;
    logic signed [8:0] y_nxt;

    always_ff @(posedge xclk) begin
        for (int j = 0; j < DLY - 1; j++) begin
            sr[j] <= sr[j+1];
        end
        sr[DLY-1] <= din;
        pfi_dl    <= {pfi_dl[DLY-2:0], pre_first_in};
        en_dl     <= {en_dl[DLY-2:0], en};
    end

    // window counter restarts 17 cycles after the tile start
    always_ff @(posedge xclk) begin
        if (pfi_dl[DLY-1])
            cnt <= 8'h0;
        else
            cnt <= cnt + 8'h1;

        if (pfi_dl[DLY-1])
            act <= 1'b1;
        else if (cnt == LAST[7:0])
            act <= 1'b0;

        if (pfi_dl[DLY-1]) begin
            scale_l <= scale_diff;  // hold through the delayed window
            hdr_l   <= hdr;
            bp_l    <= bayer_phase;
        end
    end

    assign pix_par  = {cnt[4], cnt[0]};
    assign top_left = pix_par == 2'b00;

    // with sr[0] at a cell top-left the whole cell is at hand
    always_comb begin
        case (bp_l)
            2'd0:    cell_base = sr[0];
            2'd1:    cell_base = sr[1];
            2'd2:    cell_base = sr[16];  // next row
            default: cell_base = din;     // next row, next col
        endcase
    end

    always_ff @(posedge xclk) begin
        if (top_left)
            base_mem[cnt[3:1]] <= cell_base;
    end

    assign base = top_left ? cell_base : base_mem[cnt[3:1]];
    assign diff = $signed({1'b0, sr[0]}) - $signed({1'b0, base});

    always_comb begin
        if (pix_par == bp_l || (hdr_l && pix_par == ~bp_l))
            y_nxt = cs_level_shift(sr[0]);  // base, or diagonal green in hdr
        else if (scale_l)
            y_nxt = diff >>> 1;
        else
            y_nxt = diff;
    end

    always_ff @(posedge xclk) begin
        pix.we        <= en_dl[DLY-1] & act;
        pix.addr      <= {cnt[4], cnt[7:5], cnt[0], cnt[3:1]};  // jp4 order
        pix.y         <= y_nxt;
        pre_first_out <= pfi_dl[DLY-1];
    end

    // the last write of a tile is followed by silence or a new tile
    a_tile_len: assert property (@(posedge xclk)
        pix.we && pix.addr == 8'hff && !pre_first_out |=> !pix.we);

endmodule

// ==== cs_convert.sv ====
module cs_convert (
    input  logic            xclk,
    input  logic            rst,
    input  cs_pkg::cs_cfg_t cfg,
    input  logic [7:0]      mb_din,
    input  logic            pre_first_in,
    output cs_pkg::cs_pix_t pix_out,
    output logic            pre_first_out
);
    import cs_pkg::*;

    cs_cfg_t    cfg_r;      // config of the tile now entering
    logic [2:0] en;         // {jp4diff, jp4, mono16}
    cs_pix_t    mono_pix;
    cs_pix_t    jp4_pix;
    cs_pix_t    diff_pix;
    cs_pix_t    src;
    logic       mono_pfo;
    logic       jp4_pfo;
    logic       diff_pfo;

    always_ff @(posedge xclk) begin
        if (rst)
            cfg_r <= '0;
        else if (pre_first_in)
            cfg_r <= cfg;   // mode changes only at tile start
    end

    assign en[0] = cfg_r.frame_en && cfg_r.conv_type == CS_MONO16;
    assign en[1] = cfg_r.frame_en && cfg_r.conv_type == CS_JP4;
    assign en[2] = cfg_r.frame_en && cfg_r.conv_type == CS_JP4DIFF;

    cs_mono16 u_mono16 (
        .xclk          (xclk),
        .en            (en[0]),
        .din           (mb_din),
        .pre_first_in  (pre_first_in),
        .pix           (mono_pix),
        .pre_first_out (mono_pfo)
    );

    cs_jp4 u_jp4 (
        .xclk          (xclk),
        .en            (en[1]),
        .din           (mb_din),
        .pre_first_in  (pre_first_in),
        .pix           (jp4_pix),
        .pre_first_out (jp4_pfo)
    );

    cs_jp4diff u_jp4diff (
        .xclk          (xclk),
        .en            (en[2]),
        .din           (mb_din),
        .pre_first_in  (pre_first_in),
        .scale_diff    (cfg_r.scale_diff),
        .hdr           (cfg_r.hdr),
        .bayer_phase   (cfg_r.bayer_phase),
        .pix           (diff_pix),
        .pre_first_out (diff_pfo)
    );

    // pick by write enable, not by cfg_r: the tail of the previous tile
    // may still be in flight after the next pre_first_in
    always_comb begin
        if (diff_pix.we)
            src = diff_pix;    // oldest pipeline first
        else if (jp4_pix.we)
            src = jp4_pix;
        else
            src = mono_pix;
    end

    always_ff @(posedge xclk) begin
        pix_out.addr <= {src.addr[7], src.addr[3], src.addr[6:4], src.addr[2:0]};
        pix_out.y    <= src.y;
        if (rst) begin
            pix_out.we    <= 1'b0;
            pre_first_out <= 1'b0;
        end else begin
            pix_out.we    <= src.we;
            pre_first_out <= |(en & {diff_pfo, jp4_pfo, mono_pfo});  // disabled tiles stay silent
        end
    end

    // one converter at a time, switching only right after a tile start
    a_one_conv: assert property (@(posedge xclk) disable iff (rst)
        $onehot0(en) && (!$changed(en) || $past(pre_first_in)));

endmodule

// ==== cs_top.sv ====
`include "cs_params.svh"

module cs_top (
    input  logic                  xclk,
    input  logic                  rst,
    input  logic [`CS_APB_AW-1:0] paddr,
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  logic [31:0]           pwdata,
    output logic [31:0]           prdata,
    output logic                  pready,
    output logic                  pslverr,
    input  logic [7:0]            mb_din,        // bayer pixels, scanline order
    input  logic                  pre_first_in,
    output cs_pkg::cs_pix_t       pix_out,       // to the 256-byte tile buffer
    output logic                  pre_first_out
);
    import cs_pkg::*;

    cs_cfg_t cfg;

    cs_apb_regs u_regs (
        .xclk      (xclk),
        .rst       (rst),
        .paddr     (paddr),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr),
        .cfg       (cfg),
        .tile_done (pre_first_out)  // tile counter
    );

    cs_convert u_convert (
        .xclk          (xclk),
        .rst           (rst),
        .cfg           (cfg),
        .mb_din        (mb_din),
        .pre_first_in  (pre_first_in),
        .pix_out       (pix_out),
        .pre_first_out (pre_first_out)
    );

endmodule

// ==== tb_clk_gen.sv ====
module tb_clk_gen (
    output logic xclk,
    output logic rst
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam int RST_CYCLES = 16;

    initial begin
        xclk = 1'b0;
        forever #2 xclk = ~xclk;  // 4 ns period
    end

    initial begin
        rst = 1'b1;
        repeat (RST_CYCLES) @(posedge xclk);
        rst <= 1'b0;
    end

endmodule

// ==== tb_cs_top.sv ====
`include "cs_params.svh"

module tb_cs_top;
    timeunit 1ns;
    timeprecision 100ps;
    import cs_pkg::*;

    localparam int NT    = 24;                 // tiles in the run
    localparam int LIMIT = NT * 300 + 1000;    // cycle budget

    logic                  xclk;
    logic                  rst;
    logic [`CS_APB_AW-1:0] paddr;
    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    logic [31:0]           pwdata;
    logic [31:0]           prdata;
    logic                  pready;
    logic                  pslverr;
    logic [7:0]            mb_din;
    logic                  pre_first_in;
    cs_pix_t               pix_out;
    logic                  pre_first_out;

    integer            seed = 32'h1a10_3826;
    int                cyc = 0;
    logic [7:0]        px [0:NT-1][0:255];       // pixels of every tile
    cs_cfg_t           tcfg [0:NT-1];
    logic              b2b [0:NT-1];             // starts with the last pixel of the tile before
    logic signed [8:0] exp_y [0:255];            // scoreboard by output address
    int                exp_cyc [0:255];
    logic              pending [0:255];
    int                pfo_q [$];                // expected pre_first_out cycles
    int                n_writes = 0;
    int                n_enabled = 0;

    tb_clk_gen u_clk (.xclk(xclk), .rst(rst));

    cs_top DUT (
        .xclk          (xclk),
        .rst           (rst),
        .paddr         (paddr),
        .psel          (psel),
        .penable       (penable),
        .pwrite        (pwrite),
        .pwdata        (pwdata),
        .prdata        (prdata),
        .pready        (pready),
        .pslverr       (pslverr),
        .mb_din        (mb_din),
        .pre_first_in  (pre_first_in),
        .pix_out       (pix_out),
        .pre_first_out (pre_first_out)
    );

    task automatic check(input logic [31:0] act, input logic [31:0] exp, input string what);
        if (act !== exp) begin
            $display("MISMATCH at %0t: %s got %0h expected %0h", $time, what, act, exp);
            $display("Result: FAILED");
            $fatal(1);
        end
    endtask

    // output latency in cycles for a mode, pixel and tile start alike
    function automatic int latency(input cs_cfg_t c);
        return (c.conv_type == CS_JP4DIFF) ? 2 + `CS_JP4DIFF_DELAY : 2;
    endfunction

    // raster index to tile buffer address
    function automatic logic [7:0] block_addr(input cs_cfg_t c, input int i);
        logic [3:0] r;
        logic [3:0] col;
        logic [7:0] raw;
        r   = i[7:4];
        col = i[3:0];
        if (c.conv_type == CS_MONO16)
            raw = i[7:0];
        else
            raw = {r[0], r[3:1], col[0], col[3:1]};  // bayer color split
        return {raw[7], raw[3], raw[6:4], raw[2:0]};
    endfunction

    function automatic logic signed [8:0] model_y(input int t, input int i);
        cs_cfg_t    c;
        logic [1:0] par;
        logic [3:0] r;
        logic [3:0] col;
        int         p;
        int         b;
        int         d;
        c   = tcfg[t];
        r   = i[7:4];
        col = i[3:0];
        p   = px[t][i];
        par = {r[0], col[0]};
        if (c.conv_type != CS_JP4DIFF)
            return 9'(p - 128);
        if (par == c.bayer_phase || (c.hdr && par == ~c.bayer_phase))
            return 9'(p - 128);  // base color, or diagonal in hdr
        b = px[t][{r[3:1], c.bayer_phase[1], col[3:1], c.bayer_phase[0]}];
        d = p - b;
        if (c.scale_diff)
            d = d >>> 1;
        return 9'(d);
    endfunction

    task automatic apb_xfer(input logic wr, input logic [3:0] a, input logic [31:0] wd,
                            output logic [31:0] rd, output logic err);
        @(negedge xclk);
        psel    = 1'b1;  // setup phase
        penable = 1'b0;
        pwrite  = wr;
        paddr   = a;
        pwdata  = wd;
        @(negedge xclk);
        penable = 1'b1;
        #1;
        check(pready, 1'b1, "pready");
        rd  = prdata;
        err = pslverr;
        @(negedge xclk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    // bookkeeping at the cycle pre_first_in is driven
    task automatic note_start(input int t);
        if (tcfg[t].frame_en) begin
            pfo_q.push_back(cyc + latency(tcfg[t]));
            n_enabled++;
        end
    endtask

    task automatic drive_pixels(input int t);
        logic [7:0] a;
        for (int i = 0; i < 256; i++) begin
            @(negedge xclk);
            mb_din       = px[t][i];
            pre_first_in = (i == 255) && (t + 1 < NT) && b2b[t+1];
            if (tcfg[t].frame_en) begin
                a          = block_addr(tcfg[t], i);
                exp_y[a]   = model_y(t, i);
                exp_cyc[a] = cyc + latency(tcfg[t]);
                pending[a] = 1'b1;
            end
            if (pre_first_in)
                note_start(t + 1);
        end
    endtask

    always @(posedge xclk) begin
        cyc <= cyc + 1;
        if (cyc > LIMIT) begin
            $display("timeout after %0d cycles, stream never drained", cyc);
            $display("Result: FAILED");
            $fatal(1);
        end
    end

    // output monitor samples on the falling edge
    always @(negedge xclk) begin
        if (!rst) begin
            if (pix_out.we) begin
                check(pending[pix_out.addr], 1'b1, "write to address with no pending pixel");
                check(cyc, exp_cyc[pix_out.addr], "write cycle");
                check(pix_out.y, exp_y[pix_out.addr], "sample value");
                pending[pix_out.addr] = 1'b0;
                n_writes++;
            end
            if (pre_first_out) begin
                if (pfo_q.size() == 0) begin
                    $display("pre_first_out pulsed with no enabled tile in flight");
                    $display("Result: FAILED");
                    $fatal(1);
                end
                check(cyc, pfo_q.pop_front(), "pre_first_out cycle");
            end
        end
    end

    initial begin
        logic [31:0] rd;
        logic        err;
        logic        err2;
        int          idx;

        paddr        = '0;
        psel         = 1'b0;
        penable      = 1'b0;
        pwrite       = 1'b0;
        pwdata       = '0;
        mb_din       = '0;
        pre_first_in = 1'b0;
        for (int a = 0; a < 256; a++)
            pending[a] = 1'b0;

        // tile configs and random pixels
        for (int t = 0; t < NT; t++) begin
            for (int i = 0; i < 256; i++)
                px[t][i] = $random(seed);
            tcfg[t] = '0;
            b2b[t]  = 1'b0;
        end
        tcfg[0] = '{bayer_phase: 2'd0, hdr: 1'b0, scale_diff: 1'b0,
                    conv_type: CS_MONO16, frame_en: 1'b1};
        tcfg[1] = tcfg[0];
        tcfg[1].conv_type = CS_JP4;
        tcfg[2] = tcfg[0];
        tcfg[2].frame_en = 1'b0;       // silent tile
        tcfg[3] = tcfg[1];
        for (int t = 4; t < 20; t++) begin
            idx = t - 4;               // all phase, scale and hdr combos
            tcfg[t] = '{bayer_phase: idx[1:0], hdr: idx[3], scale_diff: idx[2],
                        conv_type: CS_JP4DIFF, frame_en: 1'b1};
        end
        tcfg[20] = tcfg[19];
        tcfg[20].frame_en = 1'b0;
        tcfg[21] = tcfg[0];
        tcfg[22] = tcfg[0];
        tcfg[23] = tcfg[1];
        for (int t = 1; t < 23; t++)
            b2b[t] = 1'b1;

        @(negedge rst);
        @(negedge xclk);

        // register access checks
        apb_xfer(1'b0, `CS_REG_STATUS, 32'h0, rd, err);
        check(err, 1'b0, "status read error");
        check(rd, 32'h0, "status after reset");
        apb_xfer(1'b1, `CS_REG_MODE, {24'h0, 8'hE9}, rd, err);
        check(err, 1'b0, "mode write error");
        apb_xfer(1'b0, `CS_REG_MODE, 32'h0, rd, err);
        check(rd, 32'hE9, "mode readback");
        apb_xfer(1'b1, `CS_REG_MODE, 32'h0F, rd, err);  // conv_type 7
        check(err, 1'b1, "illegal conv_type error");
        apb_xfer(1'b0, `CS_REG_MODE, 32'h0, rd, err);
        check(rd, 32'hE9, "mode kept after illegal write");
        apb_xfer(1'b0, 4'h8, 32'h0, rd, err);
        check(err, 1'b1, "bad address error");
        apb_xfer(1'b1, `CS_REG_MODE, 32'h0, rd, err);  // conv_type 0 is no mode
        check(err, 1'b1, "conv_type 0 rejected");

        for (int t = 0; t < NT; t++) begin
            if (!b2b[t]) begin
                repeat (30) @(negedge xclk);
                apb_xfer(1'b1, `CS_REG_MODE, {24'h0, tcfg[t]}, rd, err);
                check(err, 1'b0, "tile mode write error");
                @(negedge xclk);
                pre_first_in = 1'b1;
                note_start(t);
            end
            // next mode is written mid-tile and must not touch this one
            fork
                drive_pixels(t);
                begin
                    if (t + 1 < NT && b2b[t+1]) begin
                        repeat (100) @(negedge xclk);
                        apb_xfer(1'b1, `CS_REG_MODE, {24'h0, tcfg[t+1]}, rd, err2);
                        check(err2, 1'b0, "mid-tile mode write error");
                    end
                end
            join
        end

        repeat (40) @(negedge xclk);
        for (int a = 0; a < 256; a++)
            check(pending[a], 1'b0, "pixel never written");
        check(n_writes, n_enabled * `CS_TILE_PIXELS, "write count");
        check(pfo_q.size(), 0, "missing pre_first_out pulses");
        apb_xfer(1'b0, `CS_REG_STATUS, 32'h0, rd, err);
        check(rd, n_enabled, "tile counter");

        $display("Result: PASSED");
        $finish;
    end

endmodule

// ==== compile.f ====
+incdir+.
cs_pkg.sv
cs_apb_regs.sv
cs_mono16.sv
cs_jp4.sv
cs_jp4diff.sv
cs_convert.sv
cs_top.sv
tb_clk_gen.sv
tb_cs_top.sv
